/* rtl/sePkg.sv */
//--------------------
// sound effect shared types
// byte and sample types, saturation limits
// and the silence value used by the mixer
//--------------------
`default_nettype none

package sePkg;

    //--------------------
    // data types
    //--------------------
    typedef logic [7:0] seByte_t;             // one loader byte
    typedef logic signed [15:0] seSample_t;   // signed 16 bit pcm

    //--------------------
    // sample limits
    //--------------------
    // largest positive sample
    localparam seSample_t cSampleMax = 16'sh7fff;
    // most negative sample
    localparam seSample_t cSampleMin = 16'sh8000;

    // contributed by a channel with nothing ready
    localparam seSample_t cSilence = 16'sh0000;

endpackage

`default_nettype wire

/* rtl/seByteFifo.sv */
//--------------------
// single clock byte FIFO
// circular ram with read and write pointers
// plus an occupancy count, registered read data
//--------------------
`timescale 1ns/10ps
`default_nettype none

module seByteFifo #(
    parameter int pDepth = 256                     // power of two entry count
)(
    input  wire             iSysClk,
    input  wire             rstN,                  // sync active low
    input  sePkg::seByte_t  wrData,
    input  wire             we,
    input  wire             re,
    output sePkg::seByte_t  rdData,                // valid one cycle after re
    output logic [$clog2(pDepth):0] count,         // bytes held
    output logic            full
);

    localparam int cAddrW = $clog2(pDepth);

    sePkg::seByte_t mem [pDepth];                  // byte storage

    logic [cAddrW-1:0] wrPtr;
    logic [cAddrW-1:0] rdPtr;
    logic              wrOk;                       // write actually taken
    logic              rdOk;                       // read actually taken

    // writes while full are dropped
    assign full = (count == (cAddrW+1)'(pDepth));
    assign wrOk = we & ~full;
    assign rdOk = re & (count != '0);              // never read past empty

    //--------------------
    // pointers
    //--------------------
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
        end
        else
        begin
            if (wrOk)
                wrPtr <= wrPtr + 1'b1;             // wraps at pDepth
            if (rdOk)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    //--------------------
    // occupancy
    //--------------------
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
            count <= '0;
        else
        begin
            case ({wrOk, rdOk})
                2'b10:   count <= count + 1'b1;    // write only
                2'b01:   count <= count - 1'b1;    // read only
                default: count <= count;           // both or none
            endcase
        end
    end

    // ram write and registered read port
    always_ff @(posedge iSysClk)
    begin
        if (wrOk)
            mem[wrPtr] <= wrData;
        if (rdOk)
            rdData <= mem[rdPtr];                  // data next cycle
    end

endmodule

`default_nettype wire

/* rtl/seChannelBuffer.sv */
//--------------------
// sound effect channel buffer
// byte FIFO followed by an msb/lsb assembly FSM
// holds one sample for the mixer and reports
// a registered low level flag to the loader
//--------------------
`timescale 1ns/10ps
`default_nettype none

module seChannelBuffer #(
    parameter int pDepth = 256                     // FIFO entries
)(
    input  wire               iSysClk,
    input  wire               rstN,
    input  sePkg::seByte_t    wrData,              // loader byte
    input  wire               we,
    input  wire               take,                // mixer consumed sample
    output sePkg::seSample_t  sample,              // held sample
    output logic              sampleValid,
    output logic              full,
    output logic              needData             // below half level
);

    localparam int cCountW = $clog2(pDepth) + 1;

    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stReadMsb = 2'd1,
        stReadLsb = 2'd2,
        stStore   = 2'd3
    } state_t;

    state_t               state;
    logic                 re;
    sePkg::seByte_t       rdData;
    logic [cCountW-1:0]   count;
    logic                 canStart;

    //--------------------
    // byte storage
    //--------------------
    seByteFifo #(
        .pDepth  (pDepth)
    ) fifo (
        .iSysClk (iSysClk),
        .rstN    (rstN),
        .wrData  (wrData),
        .we      (we),
        .re      (re),
        .rdData  (rdData),
        .count   (count),
        .full    (full)
    );

    // back to back reads strobed straight from state
    assign re = (state == stReadMsb) | (state == stReadLsb);

    // slot free (or freed this cycle) and a full byte pair waiting
    assign canStart = (~sampleValid | take) & (count >= cCountW'(2));

    //--------------------
    // assembly FSM
    //--------------------
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
            state <= stIdle;
        else
        begin
            case (state)
                stIdle:    state <= canStart ? stReadMsb : stIdle;
                stReadMsb: state <= stReadLsb;
                stReadLsb: state <= stStore;       // msb on rdData now
                stStore:   state <= stIdle;        // lsb on rdData now
                default:   state <= stIdle;
            endcase
        end
    end

    // msb and lsb halves of the held sample
    always_ff @(posedge iSysClk)
    begin
        if (state == stReadLsb)
            sample[15:8] <= rdData;
        if (state == stStore)
            sample[7:0] <= rdData;
    end

    // set on store and cleared by take
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
            sampleValid <= 1'b0;
        else if (state == stStore)
            sampleValid <= 1'b1;
        else if (take)
            sampleValid <= 1'b0;
    end

    // level flag lags count by one cycle
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
            needData <= 1'b1;
        else
            needData <= (count < cCountW'(pDepth / 2));
    end

endmodule

`default_nettype wire

/* rtl/seMixer.sv */
//--------------------
// two channel saturating mixer
// on each tick adds the held samples, silence for
// any channel not ready, and clamps to 16 bits
//--------------------
`timescale 1ns/10ps
`default_nettype none

module seMixer (
    input  wire               iSysClk,
    input  wire               rstN,
    input  wire               sampleTick,          // one cycle pulse
    input  sePkg::seSample_t  sample0,
    input  wire               valid0,
    input  sePkg::seSample_t  sample1,
    input  wire               valid1,
    output logic              take0,               // consumed channel 0
    output logic              take1,
    output sePkg::seSample_t  mixSample,
    output logic              mixValid
);

    sePkg::seSample_t   in0;
    sePkg::seSample_t   in1;
    logic signed [16:0] sumFull;                   // one guard bit
    sePkg::seSample_t   sumSat;

    //--------------------
    // sum and clamp
    //--------------------
    assign in0 = valid0 ? sample0 : sePkg::cSilence;
    assign in1 = valid1 ? sample1 : sePkg::cSilence;

    // sign extended add
    assign sumFull = {in0[15], in0} + {in1[15], in1};

    always_comb
    begin
        case (sumFull[16:15])
            2'b01:   sumSat = sePkg::cSampleMax;   // positive overflow
            2'b10:   sumSat = sePkg::cSampleMin;   // negative overflow
            default: sumSat = sumFull[15:0];
        endcase
    end

    //--------------------
    // output stage
    //--------------------
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            mixValid <= 1'b0;
            take0    <= 1'b0;
            take1    <= 1'b0;
        end
        else
        begin
            mixValid <= sampleTick;
            take0    <= sampleTick & valid0;       // only what was used
            take1    <= sampleTick & valid1;
        end
    end

    // held until the next tick
    always_ff @(posedge iSysClk)
    begin
        if (sampleTick)
            mixSample <= sumSat;
    end

endmodule

`default_nettype wire

/* rtl/seSoundTop.sv */
//--------------------
// sound effect playback top
// two channel buffers side by side feeding
// one saturating mixer
//--------------------
`timescale 1ns/10ps
`default_nettype none

module seSoundTop #(
    parameter int pDepth = 256                     // per channel FIFO depth
)(
    input  wire               iSysClk,
    input  wire               rstN,
    input  sePkg::seByte_t    wrData0,
    input  wire               we0,
    input  sePkg::seByte_t    wrData1,
    input  wire               we1,
    input  wire               sampleTick,
    output sePkg::seSample_t  mixSample,
    output logic              mixValid,
    output logic              full0,
    output logic              full1,
    output logic              needData0,
    output logic              needData1
);

    sePkg::seSample_t sample0;
    sePkg::seSample_t sample1;
    logic             valid0;
    logic             valid1;
    logic             take0;                       // mixer back to channel
    logic             take1;

    //--------------------
    // channel buffers
    //--------------------
    seChannelBuffer #(
        .pDepth      (pDepth)
    ) chBuf0 (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .wrData      (wrData0),
        .we          (we0),
        .take        (take0),
        .sample      (sample0),
        .sampleValid (valid0),
        .full        (full0),
        .needData    (needData0)
    );

    seChannelBuffer #(
        .pDepth      (pDepth)
    ) chBuf1 (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .wrData      (wrData1),
        .we          (we1),
        .take        (take1),
        .sample      (sample1),
        .sampleValid (valid1),
        .full        (full1),
        .needData    (needData1)
    );

    // mixer
    seMixer mixer (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .sampleTick  (sampleTick),
        .sample0     (sample0),
        .valid0      (valid0),
        .sample1     (sample1),
        .valid1      (valid1),
        .take0       (take0),
        .take1       (take1),
        .mixSample   (mixSample),
        .mixValid    (mixValid)
    );

endmodule

`default_nettype wire

/* tests/tbClock.sv */
//--------------------
// testbench clock and reset
// 8 ns clock, active low reset for 3 cycles
//--------------------
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic sysClk,
    output logic rstN
);

    initial
    begin
        sysClk = 1'b0;
        forever #4 sysClk = ~sysClk;            // 8 ns period
    end

    // released just after the third edge
    initial
    begin
        rstN = 1'b0;
        repeat (3) @(posedge sysClk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/seSound_chk.sv */
//--------------------
// sound top protocol assertions
// mixValid pulse width and take handshake rules
//--------------------
`timescale 1ns/10ps
`default_nettype none

module seSound_chk (
    input wire iSysClk,
    input wire rstN,
    input wire sampleTick,
    input wire mixValid,
    input wire valid0,
    input wire valid1,
    input wire take0,
    input wire take1
);

    // one cycle pulse only
    assert property (@(posedge iSysClk) disable iff (!rstN) mixValid |=> !mixValid)
        else $error("mixValid high for two cycles");

    // take only while the channel holds a sample
    assert property (@(posedge iSysClk) disable iff (!rstN) take0 |-> valid0)
        else $error("take0 without sampleValid");
    assert property (@(posedge iSysClk) disable iff (!rstN) take1 |-> valid1)
        else $error("take1 without sampleValid");

    // take follows a tick by one cycle
    assert property (@(posedge iSysClk) disable iff (!rstN) (take0 | take1) |-> $past(sampleTick))
        else $error("take without preceding sampleTick");

endmodule

bind seSoundTop seSound_chk chk (
    .iSysClk    (iSysClk),
    .rstN       (rstN),
    .sampleTick (sampleTick),
    .mixValid   (mixValid),
    .valid0     (valid0),
    .valid1     (valid1),
    .take0      (take0),
    .take1      (take1)
);

`default_nettype wire

/* tests/tbSeSound.sv */
//--------------------
// sound effect playback testbench
// lfsr driven loader bytes and ticks, reference
// model of byte queues, fetch timing and mixing
//--------------------
`timescale 1ns/10ps
`default_nettype none

module tbSeSound;

    localparam int cDepth     = 16;
    localparam int cTicks     = 150;
    localparam int cMaxGap    = 16;
    localparam int cTimeoutNs = cTicks * cMaxGap * 8 + 2000;

    logic             sysClk;
    logic             rstN;
    sePkg::seByte_t   wrData0;
    sePkg::seByte_t   wrData1;
    logic             we0;
    logic             we1;
    logic             sampleTick;
    sePkg::seSample_t mixSample;
    logic             mixValid;
    logic             full0;
    logic             full1;
    logic             needData0;
    logic             needData1;

    logic [31:0]      lfsr = 32'h3d9;

    // model state per channel
    sePkg::seByte_t   bq [2][$];              // bytes not yet taken
    int               be [2][$];              // edge each byte was written
    sePkg::seByte_t   dq [2][$];              // directed bytes waiting
    int               mCnt [2];               // fifo occupancy
    int               prevCnt [2];
    int               fetchF [2];             // fetch start edge of head pair
    int               freeEdge [2];           // edge the held slot frees up
    logic             wrPend [2];
    sePkg::seByte_t   wrByte [2];

    int               cyc;
    int               gap;
    int               ticksIssued;
    logic             tickPend;
    int               expMix;
    int               dataErrors;
    int               flagErrors;
    int               timingErrors;

    tbClock clkGen (
        .sysClk (sysClk),
        .rstN   (rstN)
    );

    seSoundTop #(
        .pDepth     (cDepth)
    ) seSoundTop_inst (
        .iSysClk    (sysClk),
        .rstN       (rstN),
        .wrData0    (wrData0),
        .we0        (we0),
        .wrData1    (wrData1),
        .we1        (we1),
        .sampleTick (sampleTick),
        .mixSample  (mixSample),
        .mixValid   (mixValid),
        .full0      (full0),
        .full1      (full1),
        .needData0  (needData0),
        .needData1  (needData1)
    );

    // fibonacci lfsr stepped once per bit
    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int satAdd(input int a, input int b);
        int s;
        s = a + b;
        if (s > int'(sePkg::cSampleMax))
            s = int'(sePkg::cSampleMax);
        else if (s < int'(sePkg::cSampleMin))
            s = int'(sePkg::cSampleMin);
        return s;
    endfunction

    //--------------------
    // watchdog
    //--------------------
    initial
    begin
        #(cTimeoutNs);
        $display("watchdog: run did not finish in %0d ns", cTimeoutNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //--------------------
    // stimulus, model, checks
    //--------------------
    initial
    begin
        logic [31:0] r;
        logic        tickNow;
        logic        done;
        logic        fullObs [2];
        logic        needObs [2];
        int          s [2];
        int          t;

        wrData0    = '0;
        wrData1    = '0;
        we0        = 1'b0;
        we1        = 1'b0;
        sampleTick = 1'b0;
        for (int c = 0; c < 2; c++)
        begin
            mCnt[c]     = 0;
            prevCnt[c]  = 0;
            fetchF[c]   = -1;
            freeEdge[c] = 0;
            wrPend[c]   = 1'b0;
            wrByte[c]   = '0;
        end
        cyc          = 0;
        gap          = 8;
        ticksIssued  = 0;
        tickPend     = 1'b0;
        expMix       = 0;
        dataErrors   = 0;
        flagErrors   = 0;
        timingErrors = 0;
        done         = 1'b0;

        wait (rstN === 1'b1);
        while (!done)
        begin
            @(posedge sysClk);
            cyc = cyc + 1;
            #1;
            fullObs[0] = full0;
            fullObs[1] = full1;
            needObs[0] = needData0;
            needObs[1] = needData1;

            for (int c = 0; c < 2; c++)
            begin
                if (wrPend[c])                   // byte sampled this edge
                begin
                    bq[c].push_back(wrByte[c]);
                    be[c].push_back(cyc);
                    mCnt[c]++;
                end
                // head pair fetch starts once slot free and pair complete
                if (fetchF[c] < 0 && bq[c].size() >= 2)
                    fetchF[c] = (be[c][1] + 1 > freeEdge[c]) ? be[c][1] + 1 : freeEdge[c];
                if (fetchF[c] >= 0 && (cyc == fetchF[c] + 1 || cyc == fetchF[c] + 2))
                    mCnt[c]--;                   // msb then lsb leave fifo
                if (fullObs[c] !== (mCnt[c] == cDepth))
                begin
                    $display("** Error @%0t: ch%0d full=%b, occupancy %0d",
                             $time, c, fullObs[c], mCnt[c]);
                    flagErrors++;
                end
                if (needObs[c] !== (prevCnt[c] < cDepth / 2))
                begin
                    $display("** Error @%0t: ch%0d needData=%b, prior occupancy %0d",
                             $time, c, needObs[c], prevCnt[c]);
                    flagErrors++;
                end
                prevCnt[c] = mCnt[c];
            end

            if (mixValid !== tickPend)
            begin
                $display("** Error @%0t: mixValid=%b, expected %b",
                         $time, mixValid, tickPend);
                timingErrors++;
            end
            // result of the last tick, held between pulses
            if (ticksIssued > 0 && (int'(mixSample) != expMix))
            begin
                $display("** Error @%0t: mixSample=%0d, expected %0d",
                         $time, mixSample, expMix);
                dataErrors++;
            end

            // decide the tick sampled at edge cyc+1
            tickNow = 1'b0;
            if (ticksIssued < cTicks)
            begin
                if (gap == 0)
                begin
                    tickNow = 1'b1;
                    randBits(3, r);
                    gap = 7 + int'(r);           // interval 8 to 15
                end
                else
                    gap--;
            end
            if (tickNow)
            begin
                t = cyc + 1;
                for (int c = 0; c < 2; c++)
                begin
                    s[c] = int'(sePkg::cSilence);
                    if (fetchF[c] >= 0 && t >= fetchF[c] + 4)
                    begin
                        s[c] = int'($signed({bq[c][0], bq[c][1]}));
                        void'(bq[c].pop_front());
                        void'(bq[c].pop_front());
                        void'(be[c].pop_front());
                        void'(be[c].pop_front());
                        fetchF[c]   = -1;
                        freeEdge[c] = t + 1;
                    end
                end
                expMix = satAdd(s[0], s[1]);
                ticksIssued++;
                if (ticksIssued == 140)          // directed clamp pairs
                begin
                    for (int c = 0; c < 2; c++)
                    begin
                        dq[c] = '{8'h7f, 8'hff, 8'h80, 8'h00};
                    end
                end
            end

            // loader writes held off while full
            for (int c = 0; c < 2; c++)
            begin
                wrPend[c] = 1'b0;
                if (fullObs[c])
                    continue;
                if ((ticksIssued >= 2 && ticksIssued < 40 && c == 0) ||
                    (ticksIssued >= 40 && ticksIssued < 120))
                begin
                    randBits(1, r);
                    if (r[0])
                    begin
                        randBits(8, r);
                        wrPend[c] = 1'b1;
                        wrByte[c] = r[7:0];
                    end
                end
                else if (ticksIssued >= 140 && dq[c].size() > 0)
                begin
                    wrPend[c] = 1'b1;
                    wrByte[c] = dq[c].pop_front();
                end
            end
            we0        = wrPend[0];
            wrData0    = wrByte[0];
            we1        = wrPend[1];
            wrData1    = wrByte[1];
            sampleTick = tickNow;
            tickPend   = tickNow;
            done       = (ticksIssued == cTicks) && !tickPend;
        end

        $display("checks done: %0d data errors, %0d flag errors, %0d timing errors",
                 dataErrors, flagErrors, timingErrors);
        if (dataErrors + flagErrors + timingErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/sePkg.sv
rtl/seByteFifo.sv
rtl/seChannelBuffer.sv
rtl/seMixer.sv
rtl/seSoundTop.sv
tests/tbClock.sv
tests/seSound_chk.sv
tests/tbSeSound.sv

/* Bender.yml */
package:
  name: se_sound

sources:
  - rtl/sePkg.sv
  - rtl/seByteFifo.sv
  - rtl/seChannelBuffer.sv
  - rtl/seMixer.sv
  - rtl/seSoundTop.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/seSound_chk.sv
      - tests/tbSeSound.sv
